/* hdl/chan_pkg.sv */
package chan_pkg;

  // word widths shared by the fabric and the pipeline
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;
  localparam int CMD_W      = 32;
  localparam int MSG_CODE_W = 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CMD_W-1:0]  cmd_t;

  // instruction word layout from the msb down
  // code[31:28] cond[27:26] dst[25:24] src0[23:22] src1[21:20]
  localparam int CMD_CODE_LSB  = 28;
  localparam int CMD_CODE_W    = 4;
  localparam int CMD_FLAG_W    = 2;
  // lowest pair is src1 with src0 and dst stacked above
  localparam int CMD_FLAGS_LSB = 20;
  // pair index within the dst/src0/src1 slice
  localparam int FLAG_DST      = 2;
  localparam int FLAG_SRC0     = 1;
  localparam int FLAG_SRC1     = 0;

  // channel instruction
  localparam logic [CMD_CODE_W-1:0] CMD_CHN = 4'hc;

  // inter-cpu message codes
  typedef enum logic [MSG_CODE_W-1:0] {
    NONE             = 8'h00,
    CHAN_SET         = 8'h21,
    CHAN_GET         = 8'h22,
    THREAD_ADDRESS   = 8'h30,
    CHAN_OP_ACCEPTED = 8'h41,
    CHAN_NO_RESULTS  = 8'h42,
    CHAN_RES_RD      = 8'h43,
    CHAN_RES_WR      = 8'h44
  } chan_msg_e;

  // one fabric message in either direction
  typedef struct packed {
    chan_msg_e code;
    addr_t     addr;
    data_t     data;
  } chan_msg_t;

  // what the accepted CHN instruction does
  typedef enum logic [1:0] {
    OP_GET,
    OP_SET,
    OP_CONV,
    OP_NOP
  } chan_op_e;

  // captured operation held for the whole exchange
  typedef struct packed {
    chan_op_e kind;
    addr_t    src0;
    data_t    src1;
    data_t    base_addr_data;
  } chan_op_t;

  // thread header location
  typedef struct packed {
    addr_t base_addr;
    data_t base_addr_data;
  } thread_t;

  // execute -> result stage request
  typedef enum logic [2:0] {
    WB_NONE,
    WB_LOAD,
    WB_DONE,
    WB_RETRY,
    WB_ESCAPE,
    WB_CONV
  } wb_kind_e;

  typedef struct packed {
    wb_kind_e kind;
    data_t    data;
  } wb_req_t;

endpackage

/* hdl/chan_cmd_decode.sv */
`timescale 1ns/1ps

module chan_cmd_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               begin_i,
  input  chan_pkg::cmd_t     command_i,
  input  logic               disp_online_i,
  input  chan_pkg::data_t    src0_i,
  input  chan_pkg::data_t    src1_i,
  input  chan_pkg::data_t    base_addr_data_i,
  input  logic               busy_i,
  output chan_pkg::chan_op_t op_o,
  output logic               op_start_o
);
  import chan_pkg::*;

  logic [CMD_CODE_W-1:0]   cmd_code;
  logic [2:0][CMD_FLAG_W-1:0] flags;
  logic [2:0]              op_en;
  chan_op_e                kind;
  logic                    accept;
  chan_op_t                op_q;
  logic                    op_start_q;

  // field split
  assign cmd_code = command_i[CMD_CODE_LSB +: CMD_CODE_W];
  // condition pair above these is left to the pipeline
  assign flags    = command_i[CMD_FLAGS_LSB +: 3*CMD_FLAG_W];

  // both-ones pair means operand off
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      op_en[i] = ~&flags[i];
    end
  end

  // dst/src0/src1 enable pattern picks the operation
  always_comb begin
    case ({op_en[FLAG_DST], op_en[FLAG_SRC0], op_en[FLAG_SRC1]})
      3'b110:  kind = OP_GET;
      3'b011:  kind = OP_SET;
      3'b101:  kind = OP_CONV;
      default: kind = OP_NOP;
    endcase
  end

  // take a new CHN only when the execute stage is free
  assign accept = begin_i && (cmd_code == CMD_CHN) && disp_online_i && !busy_i;

  // operands latched so pipeline inputs may move on
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q.kind           <= kind;
      op_q.src0           <= src0_i;
      op_q.src1           <= src1_i;
      op_q.base_addr_data <= base_addr_data_i;
    end
  end

  // start strobe to sequencer and writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      op_start_q <= 1'b0;
    end else begin
      op_start_q <= accept;
    end
  end

  assign op_o       = op_q;
  assign op_start_o = op_start_q;

  // busy from the sequencer covers the start cycle so starts never repeat
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    op_start_o |=> !op_start_o
  );

endmodule

/* hdl/chan_msg_sequencer.sv */
`timescale 1ns/1ps

module chan_msg_sequencer #(
  parameter int unsigned thread_header_space = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  chan_pkg::chan_op_t  op_i,
  input  logic                op_start_i,
  input  chan_pkg::addr_t     base_addr_i,
  input  chan_pkg::data_t     base_addr_data_i,
  input  chan_pkg::chan_msg_t msg_i,
  output chan_pkg::chan_msg_t msg_o,
  output logic                msg_pulse_o,
  output logic                chan_msg_strb_o,
  output logic                busy_o,
  output chan_pkg::wb_req_t   wb_o
);
  import chan_pkg::*;

  // one state per cycle of the outbound sequence
  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ,
    S_GAP0,
    S_THREAD,
    S_GAP1,
    S_WAIT,
    S_FINISH
  } state_e;

  state_e    state_q;
  logic [1:0] hold_q;
  logic      start_idle;
  logic      msg_op;
  chan_msg_t msg_q;
  logic      pulse_q;
  logic      strb_q;
  wb_kind_e  wb_kind_d;
  wb_kind_e  wb_kind_q;
  data_t     wb_data_q;

  assign start_idle = (state_q == S_IDLE) && op_start_i;
  // get and set talk to the fabric while the rest finish locally
  assign msg_op     = (op_i.kind == OP_GET) || (op_i.kind == OP_SET);

  // writeback request for this cycle
  always_comb begin
    wb_kind_d = WB_NONE;
    if (start_idle) begin
      case (op_i.kind)
        OP_CONV: wb_kind_d = WB_CONV;
        OP_NOP:  wb_kind_d = WB_DONE;
        default: wb_kind_d = WB_NONE;
      endcase
    end else if (state_q == S_WAIT) begin
      case (msg_i.code)
        // read result only answers a get
        CHAN_RES_RD: begin
          if (op_i.kind == OP_GET) begin
            wb_kind_d = WB_LOAD;
          end
        end
        // write result only answers a set
        CHAN_RES_WR: begin
          if (op_i.kind == OP_SET) begin
            wb_kind_d = WB_DONE;
          end
        end
        CHAN_NO_RESULTS:  wb_kind_d = WB_RETRY;
        CHAN_OP_ACCEPTED: wb_kind_d = WB_ESCAPE;
        // anything else is not for us
        default:          wb_kind_d = WB_NONE;
      endcase
    end
  end

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= S_IDLE;
      hold_q    <= 2'd0;
      pulse_q   <= 1'b0;
      strb_q    <= 1'b0;
      wb_kind_q <= WB_NONE;
    end else begin
      // message pulse lasts one cycle by default
      pulse_q   <= 1'b0;
      wb_kind_q <= wb_kind_d;
      case (state_q)
        S_IDLE: begin
          if (op_start_i) begin
            if (msg_op) begin
              pulse_q <= 1'b1;
              strb_q  <= 1'b1;
              state_q <= S_REQ;
            end else begin
              state_q <= S_FINISH;
            end
          end
        end
        S_REQ: begin
          state_q <= S_GAP0;
        end
        // thread address goes out next
        S_GAP0: begin
          pulse_q <= 1'b1;
          state_q <= S_THREAD;
        end
        S_THREAD: begin
          state_q <= S_GAP1;
        end
        // request fully posted so strobe drops
        S_GAP1: begin
          strb_q  <= 1'b0;
          state_q <= S_WAIT;
        end
        // fabric always answers so no timeout
        S_WAIT: begin
          if (wb_kind_d != WB_NONE) begin
            state_q <= S_FINISH;
          end
        end
        // stay busy until the pipeline has seen completion
        S_FINISH: begin
          if (hold_q == 2'd0) begin
            state_q <= S_IDLE;
          end else begin
            hold_q <= hold_q - 2'd1;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
      // retry completes one cycle later in writeback
      if (wb_kind_d != WB_NONE) begin
        hold_q <= (wb_kind_d == WB_RETRY) ? 2'd2 : 2'd1;
      end
    end
  end

  // outbound payload
  always_ff @(posedge clk) begin
    if (start_idle) begin
      msg_q.code <= (op_i.kind == OP_SET) ? CHAN_SET : CHAN_GET;
      msg_q.addr <= op_i.src0;
      msg_q.data <= (op_i.kind == OP_SET) ? op_i.src1 : '0;
    end else if (state_q == S_GAP0) begin
      // points at the thread header, below the data area
      msg_q.code <= THREAD_ADDRESS;
      msg_q.addr <= base_addr_i - addr_t'(thread_header_space);
      msg_q.data <= base_addr_data_i - data_t'(thread_header_space);
    end
  end

  // response data rides along with the request
  always_ff @(posedge clk) begin
    if (state_q == S_WAIT) begin
      wb_data_q <= msg_i.data;
    end
  end

  // bus quiet outside the pulse
  assign msg_o           = pulse_q ? msg_q : '0;
  assign msg_pulse_o     = pulse_q;
  assign chan_msg_strb_o = strb_q;
  // covers the start cycle too so decode cannot double accept
  assign busy_o          = (state_q != S_IDLE) || op_start_i;
  assign wb_o            = '{kind: wb_kind_q, data: wb_data_q};

  // messages are separated by a gap
  a_pulse_single: assert property (
    @(posedge clk) disable iff (rst)
    msg_pulse_o |=> !msg_pulse_o
  );

  // busy only drops after a writeback request has gone out
  a_busy_until_wb: assert property (
    @(posedge clk) disable iff (rst)
    $fell(busy_o) |-> ($past(state_q) == S_FINISH)
  );

endmodule

/* hdl/chan_writeback.sv */
`timescale 1ns/1ps

module chan_writeback (
  input  logic               clk,
  input  logic               rst,
  input  chan_pkg::chan_op_t op_i,
  input  chan_pkg::wb_req_t  wb_i,
  output chan_pkg::data_t    dst_o,
  output logic               next_state_o,
  output logic               chan_escape_o,
  output logic               chan_wait_next_time_o
);
  import chan_pkg::*;

  data_t dst_q;
  data_t conv_sum;
  logic  next_state_q;
  logic  escape_q;
  logic  wait_q;
  logic  retry_q;
  logic  finish_now;

  // channel number to value
  assign conv_sum   = op_i.src1 + op_i.base_addr_data;

  // requests that end the instruction right away
  assign finish_now = (wb_i.kind == WB_LOAD) || (wb_i.kind == WB_DONE) ||
                      (wb_i.kind == WB_CONV);

  always_ff @(posedge clk) begin
    if (rst) begin
      dst_q        <= '0;
      next_state_q <= 1'b0;
      escape_q     <= 1'b0;
      wait_q       <= 1'b0;
      retry_q      <= 1'b0;
    end else begin
      // retry finishes one cycle after the level goes up
      next_state_q <= finish_now || retry_q;
      retry_q      <= (wb_i.kind == WB_RETRY);
      // thread suspended without next-state
      escape_q     <= (wb_i.kind == WB_ESCAPE);
      case (wb_i.kind)
        WB_LOAD: begin
          dst_q  <= wb_i.data;
          wait_q <= 1'b0;
        end
        WB_CONV: begin
          dst_q <= conv_sum;
        end
        // nop also lands here and leaves the level alone
        WB_DONE: begin
          if (op_i.kind == OP_SET) begin
            wait_q <= 1'b0;
          end
        end
        WB_RETRY: begin
          wait_q <= 1'b1;
        end
        default: begin
          wait_q <= wait_q;
        end
      endcase
    end
  end

  assign dst_o                 = dst_q;
  assign next_state_o          = next_state_q;
  assign chan_escape_o         = escape_q;
  assign chan_wait_next_time_o = wait_q;

  // completion and suspension are exclusive
  a_done_xor_escape: assert property (
    @(posedge clk) disable iff (rst)
    !(next_state_o && chan_escape_o)
  );

endmodule

/* hdl/chan_ctlr.sv */
`timescale 1ns/1ps

module chan_ctlr #(
  parameter int unsigned thread_header_space = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                begin_i,
  input  chan_pkg::cmd_t      command_i,
  input  logic                disp_online_i,
  input  chan_pkg::data_t     src0_i,
  input  chan_pkg::data_t     src1_i,
  input  chan_pkg::thread_t   thread_i,
  input  chan_pkg::chan_msg_t msg_i,
  output chan_pkg::chan_msg_t msg_o,
  output logic                msg_pulse_o,
  output logic                chan_msg_strb_o,
  output chan_pkg::data_t     dst_o,
  output logic                next_state_o,
  output logic                chan_escape_o,
  output logic                chan_wait_next_time_o
);
  import chan_pkg::*;

  // decode -> execute/result
  chan_op_t op;
  logic     op_start;
  // execute -> decode
  logic     busy;
  // execute -> result
  wb_req_t  wb;

  // instruction decode and operand capture
  chan_cmd_decode u_decode (
    .clk              (clk),
    .rst              (rst),
    .begin_i          (begin_i),
    .command_i        (command_i),
    .disp_online_i    (disp_online_i),
    .src0_i           (src0_i),
    .src1_i           (src1_i),
    .base_addr_data_i (thread_i.base_addr_data),
    .busy_i           (busy),
    .op_o             (op),
    .op_start_o       (op_start)
  );

  // fabric message exchange
  chan_msg_sequencer #(
    .thread_header_space (thread_header_space)
  ) u_sequencer (
    .clk              (clk),
    .rst              (rst),
    .op_i             (op),
    .op_start_i       (op_start),
    .base_addr_i      (thread_i.base_addr),
    .base_addr_data_i (thread_i.base_addr_data),
    .msg_i            (msg_i),
    .msg_o            (msg_o),
    .msg_pulse_o      (msg_pulse_o),
    .chan_msg_strb_o  (chan_msg_strb_o),
    .busy_o           (busy),
    .wb_o             (wb)
  );

  // result register and completion
  chan_writeback u_writeback (
    .clk                   (clk),
    .rst                   (rst),
    .op_i                  (op),
    .wb_i                  (wb),
    .dst_o                 (dst_o),
    .next_state_o          (next_state_o),
    .chan_escape_o         (chan_escape_o),
    .chan_wait_next_time_o (chan_wait_next_time_o)
  );

endmodule

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 16,
  parameter int release_dly  = 2
) (
  output logic clk_o,
  output logic rst_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // sync reset released just after an edge
  initial begin
    rst_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    #(release_dly);
    rst_o = 1'b0;
  end

endmodule

/* dv/chan_ctlr_tb.sv */
`timescale 1ns/1ps

module chan_ctlr_tb;
  import chan_pkg::*;

  localparam int CLK_PERIOD_NS   = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int DRV_DLY_NS      = 2;
  localparam int SEED            = 56596;
  // header space differs from the default to exercise the parameter
  localparam int unsigned THS    = 24;
  localparam int N_TESTS         = 8;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WAIT_BOUND      = 40;
  localparam int WATCHDOG_NS     = (RESET_CYCLES + N_TESTS * CYCLES_PER_TEST) * CLK_PERIOD_NS;
  // selectors for the generic waiter
  localparam int SEL_NEXT     = 0;
  localparam int SEL_ESC      = 1;
  localparam int SEL_WAIT     = 2;
  localparam int SEL_PULSE    = 3;
  localparam int SEL_STRB_LOW = 4;

  logic      clk;
  logic      rst;
  logic      cmd_begin;
  cmd_t      command;
  logic      disp_online;
  data_t     src0;
  data_t     src1;
  thread_t   thread;
  chan_msg_t msg_in;
  chan_msg_t msg_out;
  logic      msg_pulse;
  logic      msg_strb;
  data_t     dst;
  logic      next_state;
  logic      escape;
  logic      wait_next;
  string     cur_test;
  // destination value the DUT should hold
  data_t     exp_dst;

  tb_clkgen #(
    .period_ns    (CLK_PERIOD_NS),
    .reset_cycles (RESET_CYCLES),
    .release_dly  (DRV_DLY_NS)
  ) u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  chan_ctlr #(
    .thread_header_space (THS)
  ) u_chan_ctlr (
    .clk                   (clk),
    .rst                   (rst),
    .begin_i               (cmd_begin),
    .command_i             (command),
    .disp_online_i         (disp_online),
    .src0_i                (src0),
    .src1_i                (src1),
    .thread_i              (thread),
    .msg_i                 (msg_in),
    .msg_o                 (msg_out),
    .msg_pulse_o           (msg_pulse),
    .chan_msg_strb_o       (msg_strb),
    .dst_o                 (dst),
    .next_state_o          (next_state),
    .chan_escape_o         (escape),
    .chan_wait_next_time_o (wait_next)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_msg(input string what, input chan_msg_t exp, input chan_msg_t act);
    if (exp !== act) begin
      fail_run($sformatf("error %s %s: expected %h, actual %h", cur_test, what, exp, act));
    end
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (exp !== act) begin
      fail_run($sformatf("error %s %s: expected %h, actual %h", cur_test, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      fail_run($sformatf("error %s %s: expected %b, actual %b", cur_test, what, exp, act));
    end
  endtask

  // inputs change and outputs are read a little after the edge
  task automatic tick();
    @(posedge clk);
    #(DRV_DLY_NS);
  endtask

  function automatic logic watched(input int sel);
    case (sel)
      SEL_NEXT:  return next_state;
      SEL_ESC:   return escape;
      SEL_WAIT:  return wait_next;
      SEL_PULSE: return msg_pulse;
      default:   return !msg_strb;
    endcase
  endfunction

  task automatic wait_for(input int sel, input string what);
    int n;
    n = 0;
    while (!watched(sel)) begin
      if (n == WAIT_BOUND) begin
        fail_run($sformatf("%s: %s did not show up in time", cur_test, what));
      end
      tick();
      n++;
    end
  endtask

  // CHN word with en bits dst/src0/src1 and both-ones for a disabled pair
  function automatic cmd_t make_cmd(input logic [2:0] en);
    cmd_t c;
    c = $urandom;
    c[CMD_CODE_LSB +: CMD_CODE_W] = CMD_CHN;
    for (int i = 0; i < 3; i++) begin
      c[CMD_FLAGS_LSB + CMD_FLAG_W * i +: CMD_FLAG_W] = en[i] ? 2'($urandom_range(2)) : 2'b11;
    end
    return c;
  endfunction

  task automatic begin_test(input string name);
    cur_test = name;
    thread   = '{base_addr: $urandom, base_addr_data: $urandom};
    // let the previous op drain back to idle
    repeat (4) tick();
  endtask

  task automatic start_op(input logic [2:0] en, input data_t s0, input data_t s1);
    cmd_begin   = 1'b1;
    command     = make_cmd(en);
    disp_online = 1'b1;
    src0        = s0;
    src1        = s1;
    tick();
    // operands move on and the DUT keeps its captured copy
    cmd_begin = 1'b0;
    src0      = $urandom;
    src1      = $urandom;
  endtask

  // request, gap, thread address, gap, strobe release
  task automatic send_request(input logic is_set, input data_t s0, input data_t s1);
    chan_msg_t exp;
    start_op(is_set ? 3'b011 : 3'b110, s0, s1);
    wait_for(SEL_PULSE, "request pulse");
    exp.addr = s0;
    if (is_set) begin
      exp.code = CHAN_SET;
      exp.data = s1;
    end else begin
      exp.code = CHAN_GET;
      exp.data = '0;
    end
    check_msg("request", exp, msg_out);
    check_bit("strobe at request", 1'b1, msg_strb);
    tick();
    check_bit("gap after request", 1'b0, msg_pulse);
    check_bit("strobe in gap", 1'b1, msg_strb);
    wait_for(SEL_PULSE, "thread address pulse");
    exp.code = THREAD_ADDRESS;
    exp.addr = thread.base_addr - THS;
    exp.data = thread.base_addr_data - THS;
    check_msg("thread address", exp, msg_out);
    check_bit("strobe at thread address", 1'b1, msg_strb);
    wait_for(SEL_STRB_LOW, "strobe release");
  endtask

  // fabric answer one cycle wide after a short random latency
  task automatic respond(input chan_msg_e rcode, input data_t d);
    repeat ($urandom_range(3)) tick();
    msg_in = '{code: rcode, addr: $urandom, data: d};
    tick();
    msg_in = '0;
  endtask

  task automatic finish_done(input string what);
    wait_for(SEL_NEXT, what);
    check_data("dst", exp_dst, dst);
    check_bit("wait next time", 1'b0, wait_next);
    check_bit("escape", 1'b0, escape);
    tick();
    check_bit("next state single pulse", 1'b0, next_state);
  endtask

  task automatic test_reset();
    cur_test = "reset";
    check_bit("msg pulse", 1'b0, msg_pulse);
    check_bit("strobe", 1'b0, msg_strb);
    check_bit("next state", 1'b0, next_state);
    check_bit("escape", 1'b0, escape);
    check_bit("wait next time", 1'b0, wait_next);
    check_data("dst", '0, dst);
    check_msg("msg", '0, msg_out);
    // CHN offered while the dispatcher is offline
    cmd_begin   = 1'b1;
    command     = make_cmd(3'b110);
    disp_online = 1'b0;
    repeat (6) begin
      tick();
      check_bit("pulse while offline", 1'b0, msg_pulse);
      check_bit("next state while offline", 1'b0, next_state);
    end
    cmd_begin = 1'b0;
  endtask

  task automatic test_get();
    data_t rd;
    begin_test("get");
    rd = $urandom;
    send_request(1'b0, $urandom, $urandom);
    respond(CHAN_RES_RD, rd);
    exp_dst = rd;
    finish_done("read completion");
  endtask

  task automatic test_set();
    begin_test("set");
    send_request(1'b1, $urandom, $urandom);
    respond(CHAN_RES_WR, $urandom);
    finish_done("write completion");
  endtask

  task automatic test_no_results();
    begin_test("no results");
    send_request(1'($urandom_range(1)), $urandom, $urandom);
    respond(CHAN_NO_RESULTS, $urandom);
    wait_for(SEL_WAIT, "wait next time level");
    check_bit("next state before level", 1'b0, next_state);
    tick();
    check_bit("next state after level", 1'b1, next_state);
    check_bit("wait level held", 1'b1, wait_next);
    check_data("dst", exp_dst, dst);
    tick();
    check_bit("next state single pulse", 1'b0, next_state);
  endtask

  task automatic test_op_accepted();
    begin_test("op accepted");
    send_request(1'($urandom_range(1)), $urandom, $urandom);
    respond(CHAN_OP_ACCEPTED, $urandom);
    wait_for(SEL_ESC, "escape pulse");
    check_bit("next state with escape", 1'b0, next_state);
    // suspended thread never completes here
    repeat (4) begin
      tick();
      check_bit("escape single pulse", 1'b0, escape);
      check_bit("next state after escape", 1'b0, next_state);
    end
  endtask

  // convert and nop complete at A+2 with no fabric traffic
  task automatic local_op(input logic [2:0] en, input data_t s1, input logic loads);
    start_op(en, $urandom, s1);
    if (loads) begin
      exp_dst = s1 + thread.base_addr_data;
    end
    repeat (2) begin
      check_bit("no pulse", 1'b0, msg_pulse);
      check_bit("next state early", 1'b0, next_state);
      tick();
    end
    check_bit("next state at A+2", 1'b1, next_state);
    check_bit("no pulse at end", 1'b0, msg_pulse);
    check_data("dst", exp_dst, dst);
    tick();
    check_bit("next state single pulse", 1'b0, next_state);
  endtask

  task automatic test_convert();
    begin_test("convert");
    local_op(3'b101, $urandom, 1'b1);
  endtask

  task automatic test_nop();
    logic [2:0] pats [5];
    begin_test("nop");
    pats = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b111};
    local_op(pats[$urandom_range(4)], $urandom, 1'b0);
  endtask

  task automatic test_ignored();
    data_t rd;
    begin_test("ignored traffic");
    rd = $urandom;
    send_request(1'b0, $urandom, $urandom);
    // unrelated code and then a write result a get must not take
    msg_in = '{code: CHAN_SET, addr: $urandom, data: $urandom};
    tick();
    msg_in = '{code: CHAN_RES_WR, addr: $urandom, data: $urandom};
    tick();
    msg_in = '0;
    // second CHN while the first is in flight
    cmd_begin = 1'b1;
    command   = make_cmd(3'b101);
    tick();
    cmd_begin = 1'b0;
    repeat (4) begin
      check_bit("pulse while busy", 1'b0, msg_pulse);
      check_bit("next state while busy", 1'b0, next_state);
      check_bit("escape while busy", 1'b0, escape);
      tick();
    end
    respond(CHAN_RES_RD, rd);
    exp_dst = rd;
    finish_done("read completion after noise");
  endtask

  // bound from test count and per-test cycle budget
  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired, the run took too long");
  end

  initial begin
    void'($urandom(SEED));
    cmd_begin   = 1'b0;
    command     = '0;
    disp_online = 1'b0;
    src0        = '0;
    src1        = '0;
    thread      = '0;
    msg_in      = '0;
    exp_dst     = '0;
    cur_test    = "init";
    @(negedge rst);
    tick();
    test_reset();
    test_get();
    test_set();
    test_no_results();
    test_op_accepted();
    test_convert();
    test_nop();
    test_ignored();
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* project.f */
hdl/chan_pkg.sv
hdl/chan_cmd_decode.sv
hdl/chan_msg_sequencer.sv
hdl/chan_writeback.sv
hdl/chan_ctlr.sv
dv/tb_clkgen.sv
dv/chan_ctlr_tb.sv

/* Makefile */
SIM := obj_dir/Vchan_ctlr_tb

.PHONY: all run clean

all: run

# rebuild only when a source or the file list changes
$(SIM): project.f $(wildcard hdl/*.sv dv/*.sv)
	verilator --binary --timing --assert --top-module chan_ctlr_tb --Mdir obj_dir -f project.f

# the log decides pass or fail
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
